// File: project.f
+incdir+bench
design/core_pkg.sv
design/mul_stage_if.sv
design/alu_req_if.sv
design/issue_unit.sv
design/mul_stage.sv
design/alu_unit.sv
design/wb_arbiter.sv
design/reorder_buffer.sv
design/exec_core.sv
bench/core_tb.sv

// File: Bender.yml
package:
  name: exec_core

sources:
  - files:
      - design/core_pkg.sv
      - design/mul_stage_if.sv
      - design/alu_req_if.sv
      - design/issue_unit.sv
      - design/mul_stage.sv
      - design/alu_unit.sv
      - design/wb_arbiter.sv
      - design/reorder_buffer.sv
      - design/exec_core.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/core_tb.sv

// File: bench/core_model.svh
// ============================================================
// Reference model for the execution core
// ============================================================

localparam logic [31:0] LCG_SEED = 32'hbf33_33ae;

logic [31:0]             lcg_state = LCG_SEED;

// Expected commits, oldest first
logic [REG_ID_WIDTH-1:0] exp_rd_q   [$];
logic [DATA_WIDTH-1:0]   exp_data_q [$];

function automatic logic [31:0] next_rand();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

function automatic logic [DATA_WIDTH-1:0] expected_result(input exec_op_e op,
                                                          input logic [DATA_WIDTH-1:0] a,
                                                          input logic [DATA_WIDTH-1:0] b);
  logic [2*DATA_WIDTH-1:0] product;
  int                      amount;
  product = {{DATA_WIDTH{1'b0}}, a} * {{DATA_WIDTH{1'b0}}, b};
  // Only the low bits of b count as shift amount
  amount  = b % 32;
  case (op)
    OP_ADD:  return a + b;
    OP_SUB:  return a + ~b + 1;
    OP_AND:  return a & b;
    OP_OR:   return a | b;
    OP_XOR:  return a ^ b;
    OP_SLL:  return a << amount;
    OP_SRL:  return a >> amount;
    default: return product[DATA_WIDTH-1:0];
  endcase
endfunction

task automatic push_expected(input logic [REG_ID_WIDTH-1:0] rd,
                             input logic [DATA_WIDTH-1:0] data);
  exp_rd_q.push_back(rd);
  exp_data_q.push_back(data);
endtask

task automatic pop_expected(output logic [REG_ID_WIDTH-1:0] rd,
                            output logic [DATA_WIDTH-1:0] data);
  rd   = exp_rd_q.pop_front();
  data = exp_data_q.pop_front();
endtask

function automatic int pending_count();
  return exp_rd_q.size();
endfunction

// File: bench/core_tb.sv
`default_nettype none

module core_tb import core_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD    = 40;
  localparam int RESET_CYCLES  = 8;
  localparam int READY_TIMEOUT = 200;
  localparam int DRAIN_TIMEOUT = 500;
  localparam int RANDOM_OPS    = 300;

  logic                    clk_i;
  logic                    rst_i;
  logic                    issue_valid_i;
  exec_op_e                issue_op_i;
  logic [REG_ID_WIDTH-1:0] issue_rd_i;
  logic [DATA_WIDTH-1:0]   issue_a_i;
  logic [DATA_WIDTH-1:0]   issue_b_i;
  logic                    issue_ready_o;
  logic                    commit_valid_o;
  logic [REG_ID_WIDTH-1:0] commit_rd_o;
  logic [DATA_WIDTH-1:0]   commit_data_o;

  // Cycles spent waiting on issue_ready_o
  int stall_cycles;

  exec_core dut (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .issue_valid_i  (issue_valid_i),
    .issue_op_i     (issue_op_i),
    .issue_rd_i     (issue_rd_i),
    .issue_a_i      (issue_a_i),
    .issue_b_i      (issue_b_i),
    .issue_ready_o  (issue_ready_o),
    .commit_valid_o (commit_valid_o),
    .commit_rd_o    (commit_rd_o),
    .commit_data_o  (commit_data_o)
  );

  always #(CLK_PERIOD/2) clk_i = ~clk_i;

  // ============================================================
  // Reporting and checks
  // ============================================================
  task automatic stop_with_error(input string reason);
    $display("%s", reason);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string msg);
    if (actual !== expected) begin
      stop_with_error($sformatf("CHECK FAILED at %0t: %s: got %0h, expected %0h",
                                $time, msg, actual, expected));
    end
  endtask

  // Every commit must match the oldest outstanding operation
  always @(negedge clk_i) begin : commit_monitor
    logic [REG_ID_WIDTH-1:0] want_rd;
    logic [DATA_WIDTH-1:0]   want_data;
    if (rst_i === 1'b1 && commit_valid_o === 1'b1) begin
      if (pending_count() == 0) begin
        stop_with_error($sformatf("Commit at %0t with no operation outstanding", $time));
      end else begin
        pop_expected(want_rd, want_data);
        check_eq(commit_rd_o, want_rd, "commit rd");
        check_eq(commit_data_o, want_data, "commit data");
      end
    end
  end

  // ============================================================
  // Stimulus helpers
  // ============================================================
  task automatic issue_op(input exec_op_e op, input logic [REG_ID_WIDTH-1:0] rd,
                          input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b);
    int waited;
    waited        = 0;
    issue_valid_i = 1'b1;
    issue_op_i    = op;
    issue_rd_i    = rd;
    issue_a_i     = a;
    issue_b_i     = b;
    while (issue_ready_o !== 1'b1) begin
      if (waited >= READY_TIMEOUT) begin
        stop_with_error("Timeout: issue_ready_o never rose for a pending operation");
      end else begin
        stall_cycles++;
        @(negedge clk_i);
        waited++;
      end
    end
    // Accepted on the coming rising edge
    push_expected(rd, expected_result(op, a, b));
    @(negedge clk_i);
    issue_valid_i = 1'b0;
  endtask

  task automatic wait_for_drain();
    int waited;
    waited = 0;
    while (pending_count() != 0) begin
      if (waited >= DRAIN_TIMEOUT) begin
        stop_with_error("Timeout: outstanding operations never committed");
      end else begin
        @(negedge clk_i);
        waited++;
      end
    end
  endtask

  // ============================================================
  // Directed tests
  // ============================================================
  task automatic test_reset();
    int waited;
    waited = 0;
    repeat (RESET_CYCLES) begin
      @(negedge clk_i);
      check_eq(commit_valid_o, 1'b0, "commit_valid_o during reset");
      check_eq(issue_ready_o, 1'b0, "issue_ready_o during reset");
    end
    rst_i = 1'b1;
    while (issue_ready_o !== 1'b1) begin
      if (waited >= READY_TIMEOUT) begin
        stop_with_error("Timeout: issue_ready_o did not rise after reset");
      end else begin
        check_eq(commit_valid_o, 1'b0, "commit_valid_o after reset");
        @(negedge clk_i);
        waited++;
      end
    end
  endtask

  task automatic test_alu_ops();
    issue_op(OP_ADD, 5'd1, 32'h7fff_ffff, 32'h0000_0001);
    wait_for_drain();
    issue_op(OP_ADD, 5'd2, 32'hffff_ffff, 32'h0000_0002);
    wait_for_drain();
    issue_op(OP_SUB, 5'd3, 32'h0000_0005, 32'h0000_0007);
    wait_for_drain();
    issue_op(OP_AND, 5'd4, 32'hf0f0_1234, 32'h0ff0_ff00);
    wait_for_drain();
    issue_op(OP_OR, 5'd5, 32'ha5a5_0000, 32'h0000_5a5a);
    wait_for_drain();
    issue_op(OP_XOR, 5'd6, 32'hdead_beef, 32'hffff_0000);
    wait_for_drain();
    // Upper bits of b must not affect the shift
    issue_op(OP_SLL, 5'd7, 32'h0000_00f1, 32'h0000_0024);
    wait_for_drain();
    issue_op(OP_SRL, 5'd8, 32'h8000_0000, 32'hffff_ffe3);
    wait_for_drain();
    issue_op(OP_SLL, 5'd9, 32'h1234_5678, 32'h0000_0020);
    wait_for_drain();
  endtask

  task automatic test_multiplies();
    issue_op(OP_MUL, 5'd10, 32'h0000_0000, 32'h1234_5678);
    issue_op(OP_MUL, 5'd11, 32'h8765_4321, 32'h0000_0000);
    issue_op(OP_MUL, 5'd12, 32'hffff_ffff, 32'hffff_ffff);
    issue_op(OP_MUL, 5'd13, 32'hffff_ffff, 32'h0000_0002);
    repeat (6) begin
      issue_op(OP_MUL, 5'(next_rand()), next_rand(), next_rand());
    end
    wait_for_drain();
  endtask

  task automatic test_mul_then_alu();
    issue_op(OP_MUL, 5'd20, next_rand(), next_rand());
    issue_op(OP_ADD, 5'd21, 32'h0000_1000, 32'h0000_0234);
    issue_op(OP_XOR, 5'd22, 32'h5555_aaaa, 32'h0f0f_0f0f);
    issue_op(OP_SLL, 5'd23, 32'h0000_0003, 32'h0000_0010);
    issue_op(OP_SUB, 5'd24, 32'h0000_0000, 32'h0000_0001);
    wait_for_drain();
  endtask

  task automatic test_random_mix();
    logic [31:0] r;
    exec_op_e    op;
    stall_cycles = 0;
    for (int i = 0; i < RANDOM_OPS; i++) begin
      r  = next_rand();
      op = exec_op_e'(r[31:29]);
      issue_op(op, r[4:0], next_rand(), next_rand());
    end
    wait_for_drain();
    check_eq(stall_cycles != 0, 1'b1, "random mix saw issue back-pressure");
  endtask

  initial begin
    $timeformat(-9, 0, " ns", 0);
    clk_i         = 1'b0;
    rst_i         = 1'b0;
    issue_valid_i = 1'b0;
    issue_op_i    = OP_ADD;
    issue_rd_i    = '0;
    issue_a_i     = '0;
    issue_b_i     = '0;
    stall_cycles  = 0;

    test_reset();
    test_alu_ops();
    test_multiplies();
    test_mul_then_alu();
    test_random_mix();

    // Quiet period, no stray commit may follow
    repeat (10) @(negedge clk_i);
    if (pending_count() != 0) begin
      stop_with_error("Operations still outstanding at the end of the run");
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

  // Model, LCG and expected commit queue
  `include "core_model.svh"

endmodule

`default_nettype wire

// File: design/exec_core.sv
`default_nettype none

module exec_core import core_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_i,

  input  logic                    issue_valid_i,
  input  exec_op_e                issue_op_i,
  input  logic [REG_ID_WIDTH-1:0] issue_rd_i,
  input  logic [DATA_WIDTH-1:0]   issue_a_i,
  input  logic [DATA_WIDTH-1:0]   issue_b_i,
  output logic                    issue_ready_o,

  output logic                    commit_valid_o,
  output logic [REG_ID_WIDTH-1:0] commit_rd_o,
  output logic [DATA_WIDTH-1:0]   commit_data_o
);

  mul_stage_if mul_link [MUL_STAGES+1] ();
  alu_req_if   alu_req ();

  logic                     alu_hold;
  logic                     alu_grant;
  logic                     alu_res_valid;
  logic [ROB_IDX_WIDTH-1:0] alu_res_idx;
  logic [DATA_WIDTH-1:0]    alu_res_data;

  logic                     rob_full;
  logic [ROB_IDX_WIDTH-1:0] rob_tail_idx;
  logic                     rob_alloc;
  logic [REG_ID_WIDTH-1:0]  rob_alloc_rd;

  logic                     cpl_valid;
  logic [ROB_IDX_WIDTH-1:0] cpl_idx;
  logic [DATA_WIDTH-1:0]    cpl_data;

  issue_unit u_issue (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .issue_valid_i  (issue_valid_i),
    .issue_op_i     (issue_op_i),
    .issue_rd_i     (issue_rd_i),
    .issue_a_i      (issue_a_i),
    .issue_b_i      (issue_b_i),
    .issue_ready_o  (issue_ready_o),
    .alu_hold_i     (alu_hold),
    .rob_full_i     (rob_full),
    .rob_tail_idx_i (rob_tail_idx),
    .rob_alloc_o    (rob_alloc),
    .rob_alloc_rd_o (rob_alloc_rd),
    .mul_o          (mul_link[0]),
    .alu_o          (alu_req)
  );

  // Multiply chain, one link per stage
  for (genvar k = 0; k < MUL_STAGES; k++) begin : g_mul
    mul_stage u_stage (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .up_i  (mul_link[k]),
      .dn_o  (mul_link[k+1])
    );
  end

  alu_unit u_alu (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (alu_req),
    .alu_grant_i (alu_grant),
    .alu_hold_o  (alu_hold),
    .res_valid_o (alu_res_valid),
    .res_idx_o   (alu_res_idx),
    .res_data_o  (alu_res_data)
  );

  wb_arbiter u_wb_arb (
    .mul_i       (mul_link[MUL_STAGES]),
    .alu_valid_i (alu_res_valid),
    .alu_idx_i   (alu_res_idx),
    .alu_data_i  (alu_res_data),
    .alu_grant_o (alu_grant),
    .cpl_valid_o (cpl_valid),
    .cpl_idx_o   (cpl_idx),
    .cpl_data_o  (cpl_data)
  );

  reorder_buffer u_rob (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .alloc_i        (rob_alloc),
    .alloc_rd_i     (rob_alloc_rd),
    .cpl_valid_i    (cpl_valid),
    .cpl_idx_i      (cpl_idx),
    .cpl_data_i     (cpl_data),
    .full_o         (rob_full),
    .tail_idx_o     (rob_tail_idx),
    .commit_valid_o (commit_valid_o),
    .commit_rd_o    (commit_rd_o),
    .commit_data_o  (commit_data_o)
  );

endmodule

`default_nettype wire

// File: design/reorder_buffer.sv
`default_nettype none

module reorder_buffer import core_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_i,

  input  logic                     alloc_i,
  input  logic [REG_ID_WIDTH-1:0]  alloc_rd_i,

  input  logic                     cpl_valid_i,
  input  logic [ROB_IDX_WIDTH-1:0] cpl_idx_i,
  input  logic [DATA_WIDTH-1:0]    cpl_data_i,

  output logic                     full_o,
  output logic [ROB_IDX_WIDTH-1:0] tail_idx_o,

  output logic                     commit_valid_o,
  output logic [REG_ID_WIDTH-1:0]  commit_rd_o,
  output logic [DATA_WIDTH-1:0]    commit_data_o
);

  // ============================================================
  // Entry storage
  // ============================================================
  logic [REG_ID_WIDTH-1:0] rd_q   [ROB_DEPTH];
  logic [DATA_WIDTH-1:0]   data_q [ROB_DEPTH];
  logic                    done_q [ROB_DEPTH];

  logic [ROB_IDX_WIDTH-1:0] head_q;
  logic [ROB_IDX_WIDTH-1:0] tail_q;
  logic [ROB_IDX_WIDTH:0]   count_q;
  logic                     commit;

  assign full_o     = (count_q == (ROB_IDX_WIDTH+1)'(ROB_DEPTH));
  assign tail_idx_o = tail_q;

  // Head may point at an old done entry when empty
  assign commit = (count_q != '0) && done_q[head_q];

  // ============================================================
  // Pointers and flags
  // ============================================================
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      head_q         <= '0;
      tail_q         <= '0;
      count_q        <= '0;
      commit_valid_o <= 1'b0;
      for (int i = 0; i < ROB_DEPTH; i++) begin
        done_q[i] <= 1'b0;
      end
    end else begin
      commit_valid_o <= commit;

      if (alloc_i) begin
        tail_q         <= tail_q + 1'b1;
        done_q[tail_q] <= 1'b0;
      end

      // Completion never targets the slot being allocated
      if (cpl_valid_i) begin
        done_q[cpl_idx_i] <= 1'b1;
      end

      if (commit) begin
        head_q <= head_q + 1'b1;
      end

      case ({alloc_i, commit})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // ============================================================
  // Payload
  // ============================================================
  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      rd_q[tail_q] <= alloc_rd_i;
    end
    if (cpl_valid_i) begin
      data_q[cpl_idx_i] <= cpl_data_i;
    end
    if (commit) begin
      commit_rd_o   <= rd_q[head_q];
      commit_data_o <= data_q[head_q];
    end
  end

endmodule

`default_nettype wire

// File: design/wb_arbiter.sv
`default_nettype none

module wb_arbiter import core_pkg::*; (
  mul_stage_if.down                mul_i,

  input  logic                     alu_valid_i,
  input  logic [ROB_IDX_WIDTH-1:0] alu_idx_i,
  input  logic [DATA_WIDTH-1:0]    alu_data_i,
  output logic                     alu_grant_o,

  output logic                     cpl_valid_o,
  output logic [ROB_IDX_WIDTH-1:0] cpl_idx_o,
  output logic [DATA_WIDTH-1:0]    cpl_data_o
);

  // Multiply chain cannot wait, so it always wins
  assign alu_grant_o = alu_valid_i && !mul_i.valid;
  assign cpl_valid_o = mul_i.valid || alu_valid_i;

  always_comb begin
    if (mul_i.valid) begin
      cpl_idx_o  = mul_i.rob_idx;
      cpl_data_o = mul_i.partial;
    end else begin
      cpl_idx_o  = alu_idx_i;
      cpl_data_o = alu_data_i;
    end
  end

endmodule

`default_nettype wire

// File: design/alu_unit.sv
`default_nettype none

module alu_unit import core_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_i,

  alu_req_if.alu                   req_i,

  input  logic                     alu_grant_i,
  output logic                     alu_hold_o,
  output logic                     res_valid_o,
  output logic [ROB_IDX_WIDTH-1:0] res_idx_o,
  output logic [DATA_WIDTH-1:0]    res_data_o
);

  logic [SHAMT_WIDTH-1:0] shamt;
  logic [DATA_WIDTH-1:0]  result;

  assign shamt = req_i.b[SHAMT_WIDTH-1:0];

  always_comb begin : alu_calc
    case (req_i.op)
      OP_ADD:  result = req_i.a + req_i.b;
      OP_SUB:  result = req_i.a - req_i.b;
      OP_AND:  result = req_i.a & req_i.b;
      OP_OR:   result = req_i.a | req_i.b;
      OP_XOR:  result = req_i.a ^ req_i.b;
      OP_SLL:  result = req_i.a << shamt;
      OP_SRL:  result = req_i.a >> shamt;
      // Multiplies go down the chain instead
      default: result = '0;
    endcase
  end

  // Lost writeback to the multiply chain
  assign alu_hold_o = res_valid_o && !alu_grant_i;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      res_valid_o <= 1'b0;
    end else if (!alu_hold_o) begin
      res_valid_o <= req_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!alu_hold_o && req_i.valid) begin
      res_idx_o  <= req_i.rob_idx;
      res_data_o <= result;
    end
  end

endmodule

`default_nettype wire

// File: design/mul_stage.sv
`default_nettype none

module mul_stage import core_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,

  mul_stage_if.down  up_i,
  mul_stage_if.up    dn_o
);

  logic [DATA_WIDTH-1:0] chunk;
  logic [DATA_WIDTH-1:0] partial_sum;

  // One chunk of the multiplier per stage
  assign chunk       = {{(DATA_WIDTH-MUL_CHUNK){1'b0}}, up_i.multiplier[MUL_CHUNK-1:0]};
  assign partial_sum = up_i.partial + up_i.multiplicand * chunk;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      dn_o.valid <= 1'b0;
    end else begin
      dn_o.valid <= up_i.valid;
    end
  end

  // Chain never stalls, payload simply follows
  always_ff @(posedge clk_i) begin
    dn_o.rob_idx      <= up_i.rob_idx;
    dn_o.rd           <= up_i.rd;
    dn_o.partial      <= partial_sum;
    dn_o.multiplicand <= up_i.multiplicand << MUL_CHUNK;
    dn_o.multiplier   <= up_i.multiplier >> MUL_CHUNK;
  end

endmodule

`default_nettype wire

// File: design/issue_unit.sv
`default_nettype none

module issue_unit import core_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_i,

  input  logic                     issue_valid_i,
  input  exec_op_e                 issue_op_i,
  input  logic [REG_ID_WIDTH-1:0]  issue_rd_i,
  input  logic [DATA_WIDTH-1:0]    issue_a_i,
  input  logic [DATA_WIDTH-1:0]    issue_b_i,
  output logic                     issue_ready_o,

  input  logic                     alu_hold_i,
  input  logic                     rob_full_i,
  input  logic [ROB_IDX_WIDTH-1:0] rob_tail_idx_i,
  output logic                     rob_alloc_o,
  output logic [REG_ID_WIDTH-1:0]  rob_alloc_rd_o,

  mul_stage_if.up                  mul_o,
  alu_req_if.issue                 alu_o
);

  logic running_q;
  logic accept;
  logic accept_mul;

  // Stays low until the first edge after reset
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      running_q <= 1'b0;
    end else begin
      running_q <= 1'b1;
    end
  end

  assign issue_ready_o  = running_q && !alu_hold_i && !rob_full_i;
  assign accept         = issue_valid_i && issue_ready_o;
  assign accept_mul     = accept && (issue_op_i == OP_MUL);
  assign rob_alloc_o    = accept;
  assign rob_alloc_rd_o = issue_rd_i;

  // ============================================================
  // Dispatch registers
  // ============================================================
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      mul_o.valid <= 1'b0;
      alu_o.valid <= 1'b0;
    end else begin
      mul_o.valid <= accept_mul;
      // Request is kept as is while the ALU cannot take it
      if (!alu_hold_i) begin
        alu_o.valid <= accept && !accept_mul;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept_mul) begin
      mul_o.rob_idx      <= rob_tail_idx_i;
      mul_o.rd           <= issue_rd_i;
      mul_o.multiplicand <= issue_a_i;
      mul_o.multiplier   <= issue_b_i;
      mul_o.partial      <= '0;
    end
    if (accept && !accept_mul) begin
      alu_o.op      <= issue_op_i;
      alu_o.rob_idx <= rob_tail_idx_i;
      alu_o.rd      <= issue_rd_i;
      alu_o.a       <= issue_a_i;
      alu_o.b       <= issue_b_i;
    end
  end

endmodule

`default_nettype wire

// File: design/alu_req_if.sv
`default_nettype none

interface alu_req_if import core_pkg::*; ();

  logic                     valid;
  exec_op_e                 op;
  logic [ROB_IDX_WIDTH-1:0] rob_idx;
  logic [REG_ID_WIDTH-1:0]  rd;
  logic [DATA_WIDTH-1:0]    a;
  logic [DATA_WIDTH-1:0]    b;

  modport issue (
    output valid, op, rob_idx, rd, a, b
  );

  modport alu (
    input valid, op, rob_idx, rd, a, b
  );

endinterface

`default_nettype wire

// File: design/mul_stage_if.sv
`default_nettype none

interface mul_stage_if import core_pkg::*; ();

  logic                     valid;
  logic [ROB_IDX_WIDTH-1:0] rob_idx;
  logic [REG_ID_WIDTH-1:0]  rd;
  logic [DATA_WIDTH-1:0]    multiplicand;
  // Remaining multiplier bits, low chunk is consumed next
  logic [DATA_WIDTH-1:0]    multiplier;
  logic [DATA_WIDTH-1:0]    partial;

  modport up (
    output valid, rob_idx, rd,
    output multiplicand, multiplier, partial
  );

  modport down (
    input valid, rob_idx, rd,
    input multiplicand, multiplier, partial
  );

endinterface

`default_nettype wire

// File: design/core_pkg.sv
`default_nettype none

package core_pkg;

  // ============================================================
  // Datapath widths
  // ============================================================
  localparam int DATA_WIDTH   = 32;
  localparam int REG_ID_WIDTH = 5;

  // Shift amount comes from the low bits of operand b
  localparam int SHAMT_WIDTH  = 5;

  // ============================================================
  // Reorder buffer
  // ============================================================
  localparam int ROB_DEPTH     = 8;
  localparam int ROB_IDX_WIDTH = 3;

  // ============================================================
  // Multiply chain
  // ============================================================
  // Stages times chunk bits must cover the whole multiplier
  localparam int MUL_STAGES = 4;
  localparam int MUL_CHUNK  = 8;

  // Operations as they arrive from the decoder
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_SLL = 3'd5,
    OP_SRL = 3'd6,
    OP_MUL = 3'd7
  } exec_op_e;

endpackage

`default_nettype wire
